//--- hdl/dsm_handler.sv
`timescale 1ns/1ps

module dsm_handler #(
    parameter int NUM_CH = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    input  usb_cmd_proto_pkg::cmd_t    cmd,
    input  logic [NUM_CH-1:0]          dsm_signal_in,
    output logic                       rec_valid,
    output periph_pkg::upload_rec_t    rec
);

    localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

    periph_pkg::cmd_arg_u arg_view;
    logic                 start;
    logic                 busy;
    logic [CH_W-1:0]      ch_sel;
    logic [15:0]          win_cnt;
    logic                 sig_now;
    logic                 sig_prev;
    logic [15:0]          high_cnt;
    logic [15:0]          rise_cnt;
    logic [15:0]          high_nxt;
    logic [15:0]          rise_nxt;

    assign arg_view = cmd.arg;
    assign start    = cmd_valid && (cmd.code == usb_cmd_proto_pkg::cmd_dsm_measure) &&
                      (arg_view.dsm.channel < NUM_CH) && (arg_view.dsm.window != 16'd0);

    // Input is sampled as is, board level handles synchronization
    assign sig_now  = dsm_signal_in[ch_sel];
    assign high_nxt = high_cnt + {15'd0, sig_now};
    assign rise_nxt = rise_cnt + {15'd0, sig_now & ~sig_prev};

    // ======================================================================
    // Measurement window
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            win_cnt   <= 16'd0;
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= 1'b0;
            // A new command always restarts, even mid-window
            if (start) begin
                busy    <= 1'b1;
                win_cnt <= arg_view.dsm.window;
            end else if (busy) begin
                win_cnt <= win_cnt - 16'd1;
                if (win_cnt == 16'd1) begin
                    busy      <= 1'b0;
                    rec_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ch_sel   <= arg_view.dsm.channel[CH_W-1:0];
            sig_prev <= dsm_signal_in[arg_view.dsm.channel[CH_W-1:0]];
            high_cnt <= 16'd0;
            rise_cnt <= 16'd0;
        end else if (busy) begin
            sig_prev <= sig_now;
            high_cnt <= high_nxt;
            rise_cnt <= rise_nxt;
            // Last window cycle, so include it in the result
            if (win_cnt == 16'd1) begin
                rec.source <= periph_pkg::src_dsm;
                rec.data   <= {high_nxt, rise_nxt};
            end
        end
    end

endmodule

//--- hdl/frame_parser.sv
`timescale 1ns/1ps

module frame_parser (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              usb_data_in,
    input  logic                    usb_data_valid_in,
    output logic                    cmd_valid,
    output usb_cmd_proto_pkg::cmd_t cmd,
    output logic                    parse_error
);

    typedef enum logic [2:0] {
        s_hunt,
        s_sync_l,
        s_code,
        s_len,
        s_arg,
        s_csum
    } parse_state_t;

    parse_state_t            state;
    logic                    valid_d;
    logic                    byte_take;
    logic [7:0]              csum_acc;
    logic [1:0]              arg_cnt;
    logic                    len_ok;
    usb_cmd_proto_pkg::cmd_t cmd_buf;

    // Level valid from the host, one byte per rising edge
    assign byte_take = usb_data_valid_in & ~valid_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= usb_data_valid_in;
        end
    end

    // ======================================================================
    // Frame FSM
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= s_hunt;
            arg_cnt     <= 2'd0;
            len_ok      <= 1'b0;
            cmd_valid   <= 1'b0;
            parse_error <= 1'b0;
        end else begin
            cmd_valid   <= 1'b0;
            parse_error <= 1'b0;
            if (byte_take) begin
                case (state)
                    s_hunt: begin
                        if (usb_data_in == usb_cmd_proto_pkg::sync_h) begin
                            state <= s_sync_l;
                        end
                    end
                    // A bad second sync byte drops back to hunting
                    s_sync_l: begin
                        if (usb_data_in == usb_cmd_proto_pkg::sync_l) begin
                            state <= s_code;
                        end else begin
                            state <= s_hunt;
                        end
                    end
                    s_code: state <= s_len;
                    s_len: begin
                        len_ok  <= (usb_data_in == usb_cmd_proto_pkg::arg_len);
                        arg_cnt <= 2'd0;
                        state   <= s_arg;
                    end
                    s_arg: begin
                        arg_cnt <= arg_cnt + 2'd1;
                        if (arg_cnt == 2'd3) begin
                            state <= s_csum;
                        end
                    end
                    s_csum: begin
                        cmd_valid   <= len_ok && (usb_data_in == csum_acc);
                        parse_error <= !(len_ok && (usb_data_in == csum_acc));
                        state       <= s_hunt;
                    end
                    default: state <= s_hunt;
                endcase
            end
        end
    end

    // Checksum and argument assembly, qualified by the FSM state
    always_ff @(posedge clk) begin
        if (byte_take) begin
            case (state)
                s_code: begin
                    csum_acc     <= usb_data_in;
                    cmd_buf.code <= usb_data_in;
                end
                s_len: csum_acc <= csum_acc + usb_data_in;
                s_arg: begin
                    csum_acc    <= csum_acc + usb_data_in;
                    cmd_buf.arg <= {cmd_buf.arg[23:0], usb_data_in};
                end
                s_csum: cmd <= cmd_buf;
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/periph_pkg.sv
package periph_pkg;

    // ======================================================================
    // Argument views
    // ======================================================================

    // PWM set argument, channel in the top byte
    typedef struct packed {
        logic [7:0]  channel;
        logic [7:0]  duty;
        logic [15:0] reserved;
    } pwm_arg_t;

    // DSM measure argument, window is a cycle count
    typedef struct packed {
        logic [7:0]  channel;
        logic [15:0] window;
        logic [7:0]  reserved;
    } dsm_arg_t;

    // Each handler reads the same 32-bit argument word through its own view
    typedef union packed {
        pwm_arg_t pwm;
        dsm_arg_t dsm;
    } cmd_arg_u;

    // ======================================================================
    // Upload records
    // ======================================================================

    localparam logic [7:0] src_pwm = 8'h01;
    localparam logic [7:0] src_dsm = 8'h02;

    typedef struct packed {
        logic [7:0]  source;
        logic [31:0] data;
    } upload_rec_t;

endpackage

//--- hdl/pwm_handler.sv
`timescale 1ns/1ps

module pwm_handler #(
    parameter int NUM_CH  = 8,
    parameter int PWM_DIV = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    input  usb_cmd_proto_pkg::cmd_t    cmd,
    output logic [NUM_CH-1:0]          pwm_pins,
    output logic                       rec_valid,
    output periph_pkg::upload_rec_t    rec
);

    localparam int CH_W  = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
    localparam int DIV_W = (PWM_DIV > 1) ? $clog2(PWM_DIV) : 1;

    periph_pkg::cmd_arg_u arg_view;
    logic                 accept;
    logic [DIV_W-1:0]     div_cnt;
    logic                 tick;
    logic [7:0]           pwm_cnt;
    logic [7:0]           shadow_duty [NUM_CH];
    logic [7:0]           active_duty [NUM_CH];

    assign arg_view = cmd.arg;
    assign accept   = cmd_valid && (cmd.code == usb_cmd_proto_pkg::cmd_pwm_set) &&
                      (arg_view.pwm.channel < NUM_CH);

    // Prescaled period counter, one count per PWM_DIV clocks
    assign tick = (div_cnt == DIV_W'(PWM_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            pwm_cnt <= 8'd0;
            for (int i = 0; i < NUM_CH; i++) begin
                shadow_duty[i] <= 8'd0;
                active_duty[i] <= 8'd0;
            end
        end else begin
            div_cnt <= tick ? '0 : div_cnt + DIV_W'(1);
            if (tick) begin
                pwm_cnt <= pwm_cnt + 8'd1;
            end
            if (accept) begin
                shadow_duty[arg_view.pwm.channel[CH_W-1:0]] <= arg_view.pwm.duty;
            end
            // New duties only land as the counter wraps to a new period
            if (tick && pwm_cnt == 8'hFF) begin
                active_duty <= shadow_duty;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            pwm_pins[i] = (pwm_cnt < active_duty[i]);
        end
    end

    // Acknowledge with channel and duty echoed back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rec.source <= periph_pkg::src_pwm;
            rec.data   <= {arg_view.pwm.channel, arg_view.pwm.duty, 16'h0000};
        end
    end

endmodule

//--- hdl/upload_framer.sv
`timescale 1ns/1ps

module upload_framer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pwm_rec_valid,
    input  periph_pkg::upload_rec_t pwm_rec,
    input  logic                    dsm_rec_valid,
    input  periph_pkg::upload_rec_t dsm_rec,
    output logic [7:0]              usb_upload_data,
    output logic                    usb_upload_valid
);

    periph_pkg::upload_rec_t pwm_slot;
    periph_pkg::upload_rec_t dsm_slot;
    periph_pkg::upload_rec_t cur_rec;
    logic                    pwm_full;
    logic                    dsm_full;
    logic                    pwm_avail;
    logic                    dsm_avail;
    logic                    launch_pwm;
    logic                    launch_dsm;
    logic                    busy;
    logic [3:0]              byte_idx;
    logic [7:0]              csum;

    // Incoming record counts as pending, and is newer than the slot
    assign pwm_avail  = pwm_full | pwm_rec_valid;
    assign dsm_avail  = dsm_full | dsm_rec_valid;
    assign launch_pwm = !busy && pwm_avail;
    assign launch_dsm = !busy && !pwm_avail && dsm_avail;

    // ======================================================================
    // Pending slots
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_full <= 1'b0;
            dsm_full <= 1'b0;
        end else begin
            if (launch_pwm) begin
                pwm_full <= 1'b0;
            end else if (pwm_rec_valid) begin
                pwm_full <= 1'b1;
            end
            if (launch_dsm) begin
                dsm_full <= 1'b0;
            end else if (dsm_rec_valid) begin
                dsm_full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pwm_rec_valid) begin
            pwm_slot <= pwm_rec;
        end
        if (dsm_rec_valid) begin
            dsm_slot <= dsm_rec;
        end
    end

    // ======================================================================
    // Byte sequencer
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            byte_idx <= 4'd0;
        end else if (launch_pwm || launch_dsm) begin
            busy     <= 1'b1;
            byte_idx <= 4'd0;
        end else if (busy) begin
            byte_idx <= byte_idx + 4'd1;
            if (byte_idx == 4'd8) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch_pwm) begin
            cur_rec <= pwm_rec_valid ? pwm_rec : pwm_slot;
            csum    <= 8'd0;
        end else if (launch_dsm) begin
            cur_rec <= dsm_rec_valid ? dsm_rec : dsm_slot;
            csum    <= 8'd0;
        end else if (busy && byte_idx >= 4'd2 && byte_idx <= 4'd7) begin
            // Running sum over source, length and data bytes
            csum <= csum + usb_upload_data;
        end
    end

    assign usb_upload_valid = busy;

    always_comb begin
        case (byte_idx)
            4'd0:    usb_upload_data = usb_cmd_proto_pkg::resp_sync_h;
            4'd1:    usb_upload_data = usb_cmd_proto_pkg::resp_sync_l;
            4'd2:    usb_upload_data = cur_rec.source;
            4'd3:    usb_upload_data = usb_cmd_proto_pkg::arg_len;
            4'd4:    usb_upload_data = cur_rec.data[31:24];
            4'd5:    usb_upload_data = cur_rec.data[23:16];
            4'd6:    usb_upload_data = cur_rec.data[15:8];
            4'd7:    usb_upload_data = cur_rec.data[7:0];
            default: usb_upload_data = csum;
        endcase
    end

endmodule

//--- hdl/usb_cmd_bridge.sv
`timescale 1ns/1ps

module usb_cmd_bridge #(
    parameter int NUM_CH  = 8,
    parameter int PWM_DIV = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [7:0]        usb_data_in,
    input  logic              usb_data_valid_in,
    input  logic [NUM_CH-1:0] dsm_signal_in,
    output logic [NUM_CH-1:0] pwm_pins,
    output logic              parse_error,
    output logic [7:0]        usb_upload_data,
    output logic              usb_upload_valid
);

    // ======================================================================
    // Command bus and record wires
    // ======================================================================

    logic                    cmd_valid;
    usb_cmd_proto_pkg::cmd_t cmd;
    logic                    pwm_rec_valid;
    periph_pkg::upload_rec_t pwm_rec;
    logic                    dsm_rec_valid;
    periph_pkg::upload_rec_t dsm_rec;

    frame_parser frame_parser_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .usb_data_in       (usb_data_in),
        .usb_data_valid_in (usb_data_valid_in),
        .cmd_valid         (cmd_valid),
        .cmd               (cmd),
        .parse_error       (parse_error)
    );

    // Both handlers see every command and pick their own codes
    pwm_handler #(
        .NUM_CH  (NUM_CH),
        .PWM_DIV (PWM_DIV)
    ) pwm_handler_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .pwm_pins  (pwm_pins),
        .rec_valid (pwm_rec_valid),
        .rec       (pwm_rec)
    );

    dsm_handler #(
        .NUM_CH (NUM_CH)
    ) dsm_handler_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .dsm_signal_in (dsm_signal_in),
        .rec_valid     (dsm_rec_valid),
        .rec           (dsm_rec)
    );

    upload_framer upload_framer_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .pwm_rec_valid    (pwm_rec_valid),
        .pwm_rec          (pwm_rec),
        .dsm_rec_valid    (dsm_rec_valid),
        .dsm_rec          (dsm_rec),
        .usb_upload_data  (usb_upload_data),
        .usb_upload_valid (usb_upload_valid)
    );

endmodule

//--- hdl/usb_cmd_proto_pkg.sv
package usb_cmd_proto_pkg;

    // ======================================================================
    // Request framing
    // ======================================================================

    // Host to device frame: sync, sync, code, length, 4 arg bytes, checksum
    localparam logic [7:0] sync_h = 8'hAA;
    localparam logic [7:0] sync_l = 8'h55;

    // Only legal length byte, also reused as the response length
    localparam logic [7:0] arg_len = 8'd4;

    // ======================================================================
    // Response framing
    // ======================================================================

    localparam logic [7:0] resp_sync_h = 8'hAA;
    localparam logic [7:0] resp_sync_l = 8'h44;

    // ======================================================================
    // Command codes
    // ======================================================================

    localparam logic [7:0] cmd_pwm_set     = 8'h01;
    localparam logic [7:0] cmd_dsm_measure = 8'h02;

    // One checked command as broadcast on the command bus
    typedef struct packed {
        logic [7:0]  code;
        logic [31:0] arg;
    } cmd_t;

endpackage

//--- testbench/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// ======================================================================
// Failure reporting and compares
// ======================================================================

task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first failure");
endtask

task automatic check_rec(input string name, input periph_pkg::upload_rec_t exp_val,
                         input periph_pkg::upload_rec_t act_val);
    if (act_val !== exp_val) begin
        report_failure($sformatf("CHECK FAILED %s: expected %h actual %h",
                                 name, exp_val, act_val));
    end
endtask

task automatic check_count(input string name, input logic [15:0] exp_val,
                           input logic [15:0] act_val);
    if (act_val !== exp_val) begin
        report_failure($sformatf("CHECK FAILED %s: expected %0d actual %0d",
                                 name, exp_val, act_val));
    end
endtask

task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
        report_failure($sformatf("CHECK FAILED %s: expected %b actual %b",
                                 name, exp_val, act_val));
    end
endtask

// ======================================================================
// Expected records
// ======================================================================

function automatic periph_pkg::upload_rec_t expect_pwm_rec(input logic [31:0] arg);
    periph_pkg::upload_rec_t r;
    r.source = periph_pkg::src_pwm;
    // Channel and duty echoed, low half zero
    r.data   = {arg[31:16], 16'h0000};
    return r;
endfunction

// Level of the DSM stimulus j cycles after the command strobe
function automatic logic stim_level(input logic [1:0] mode, input int half_per, input int j);
    case (mode)
        2'd0:    return 1'b0;
        2'd1:    return 1'b1;
        default: return ((j / half_per) % 2) == 1;
    endcase
endfunction

function automatic periph_pkg::upload_rec_t expect_dsm_rec(input logic [31:0] arg,
                                                           input logic [1:0] mode,
                                                           input int half_per);
    periph_pkg::upload_rec_t r;
    logic [15:0]             high;
    logic [15:0]             rises;
    high  = 16'd0;
    rises = 16'd0;
    // Window samples are steps 1..window, step 0 only seeds the edge history
    for (int j = 1; j <= arg[23:8]; j++) begin
        if (stim_level(mode, half_per, j)) begin
            high = high + 16'd1;
            if (!stim_level(mode, half_per, j - 1)) begin
                rises = rises + 16'd1;
            end
        end
    end
    r.source = periph_pkg::src_dsm;
    r.data   = {high, rises};
    return r;
endfunction

// ======================================================================
// Host side frames
// ======================================================================

task automatic send_frame(input logic [7:0] code, input logic [7:0] len,
                          input logic [31:0] arg, input logic bad_csum);
    logic [0:8][7:0] frame;
    logic [7:0]      sum;
    sum = code + len + arg[31:24] + arg[23:16] + arg[15:8] + arg[7:0];
    if (bad_csum) begin
        sum = sum + 8'd1;
    end
    frame = {usb_cmd_proto_pkg::sync_h, usb_cmd_proto_pkg::sync_l, code, len, arg, sum};
    for (int i = 0; i < 9; i++) begin
        @(posedge clk);
        usb_data_in       <= frame[i];
        usb_data_valid_in <= 1'b1;
        @(posedge clk);
        usb_data_valid_in <= 1'b0;
    end
endtask

task automatic collect_response(output periph_pkg::upload_rec_t rec);
    logic [0:8][7:0] b;
    logic [7:0]      sum;
    int              waited;
    waited = 0;
    @(posedge clk);
    while (!usb_upload_valid) begin
        if (waited == resp_wait) begin
            report_failure("No response frame arrived within the wait limit");
        end
        waited = waited + 1;
        @(posedge clk);
    end
    b[0] = usb_upload_data;
    for (int i = 1; i < 9; i++) begin
        @(posedge clk);
        if (!usb_upload_valid) begin
            report_failure("Response frame ended before its ninth byte");
        end
        b[i] = usb_upload_data;
    end
    @(posedge clk);
    if (usb_upload_valid) begin
        report_failure("Upload valid stayed high after the ninth byte");
    end
    if (b[0] != usb_cmd_proto_pkg::resp_sync_h || b[1] != usb_cmd_proto_pkg::resp_sync_l) begin
        report_failure($sformatf("Response frame has bad sync bytes %h %h", b[0], b[1]));
    end
    if (b[3] != usb_cmd_proto_pkg::arg_len) begin
        report_failure($sformatf("Response frame has bad length byte %h", b[3]));
    end
    sum = b[2] + b[3] + b[4] + b[5] + b[6] + b[7];
    if (b[8] != sum) begin
        report_failure($sformatf("Response checksum %h does not match sum %h", b[8], sum));
    end
    rec = {b[2], b[4], b[5], b[6], b[7]};
endtask

`endif

//--- testbench/usb_cmd_bridge_tb.sv
`timescale 1ns/1ps

module usb_cmd_bridge_tb;

    localparam int num_ch       = 8;
    localparam int pwm_div      = 4;
    localparam int pwm_period   = 256 * pwm_div;
    localparam int n_tests      = 15;
    localparam int resp_wait    = 400;
    localparam int quiet_cycles = 40;

    // One table row with the expected records for it
    typedef struct packed {
        logic [7:0]              code;
        logic [31:0]             arg;
        logic [7:0]              len;
        logic                    bad_csum;
        logic [1:0]              dsm_mode;
        logic [7:0]              half_per;
        logic                    expect_err;
        logic                    expect_rec;
        logic                    overlap;
        logic [31:0]             arg2;
        periph_pkg::upload_rec_t exp_rec;
        periph_pkg::upload_rec_t exp_rec2;
    } test_entry_t;

    logic              clk;
    logic              rst_n;
    logic [7:0]        usb_data_in;
    logic              usb_data_valid_in;
    logic [num_ch-1:0] dsm_signal_in;
    logic [num_ch-1:0] pwm_pins;
    logic              parse_error;
    logic [7:0]        usb_upload_data;
    logic              usb_upload_valid;

    test_entry_t test_table [n_tests];
    string       test_name [n_tests];
    logic [7:0]  duty_model [num_ch];
    integer      seed = 32'h8c78;
    int          err_count = 0;
    int          frame_count = 0;
    logic        upload_prev = 1'b0;

    usb_cmd_bridge #(
        .NUM_CH  (num_ch),
        .PWM_DIV (pwm_div)
    ) usb_cmd_bridge_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .usb_data_in       (usb_data_in),
        .usb_data_valid_in (usb_data_valid_in),
        .dsm_signal_in     (dsm_signal_in),
        .pwm_pins          (pwm_pins),
        .parse_error       (parse_error),
        .usb_upload_data   (usb_upload_data),
        .usb_upload_valid  (usb_upload_valid)
    );

    `include "tb_frame_model.svh"

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // Count error pulses and frame starts over the whole run
    always @(posedge clk) begin
        upload_prev <= usb_upload_valid;
        if (parse_error) begin
            err_count <= err_count + 1;
        end
        if (usb_upload_valid && !upload_prev) begin
            frame_count <= frame_count + 1;
        end
    end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    function automatic logic [num_ch-1:0] pin_mask(input logic [7:0] ch, input logic level);
        logic [num_ch-1:0] m;
        m = '0;
        if (level && ch < num_ch) begin
            m[ch] = 1'b1;
        end
        return m;
    endfunction

    function automatic test_entry_t pwm_entry(input logic [7:0] ch, input logic [7:0] duty);
        test_entry_t e;
        e            = '0;
        e.code       = usb_cmd_proto_pkg::cmd_pwm_set;
        e.arg        = {ch, duty, 16'h0000};
        e.len        = usb_cmd_proto_pkg::arg_len;
        e.expect_rec = (ch < num_ch);
        e.exp_rec    = expect_pwm_rec(e.arg);
        return e;
    endfunction

    function automatic test_entry_t dsm_entry(input logic [7:0] ch, input logic [15:0] window,
                                              input logic [1:0] mode, input logic [7:0] hp);
        test_entry_t e;
        e            = '0;
        e.code       = usb_cmd_proto_pkg::cmd_dsm_measure;
        e.arg        = {ch, window, 8'h00};
        e.len        = usb_cmd_proto_pkg::arg_len;
        e.dsm_mode   = mode;
        e.half_per   = hp;
        e.expect_rec = (ch < num_ch) && (window != 16'd0);
        e.exp_rec    = expect_dsm_rec(e.arg, mode, hp);
        return e;
    endfunction

    task automatic build_table();
        test_entry_t e;
        logic [31:0] rnd;
        test_table[0] = pwm_entry(8'd2, 8'd77);
        test_name[0]  = "pwm_duty_mid";
        test_table[1] = pwm_entry(8'd1, 8'd255);
        test_name[1]  = "pwm_duty_full";
        // Duty zero replaces a nonzero duty on the same channel
        test_table[2] = pwm_entry(8'd2, 8'd0);
        test_name[2]  = "pwm_duty_zero";
        for (int k = 0; k < 3; k++) begin
            rnd              = $random(seed);
            test_table[3 + k] = pwm_entry(rnd[7:0] % num_ch, rnd[15:8]);
            test_name[3 + k]  = $sformatf("pwm_random_%0d", k);
        end
        test_table[6] = dsm_entry(8'd3, 16'd50, 2'd1, 8'd0);
        test_name[6]  = "dsm_const_high";
        test_table[7] = dsm_entry(8'd4, 16'd40, 2'd0, 8'd0);
        test_name[7]  = "dsm_const_low";
        test_table[8] = dsm_entry(8'd5, 16'd37, 2'd2, 8'd3);
        test_name[8]  = "dsm_square";
        e            = pwm_entry(8'd2, 8'd200);
        e.bad_csum   = 1'b1;
        e.expect_rec = 1'b0;
        e.expect_err = 1'b1;
        test_table[9] = e;
        test_name[9]  = "err_checksum";
        e            = pwm_entry(8'd2, 8'd10);
        e.len        = 8'd5;
        e.expect_rec = 1'b0;
        e.expect_err = 1'b1;
        test_table[10] = e;
        test_name[10]  = "err_length";
        e            = pwm_entry(8'd3, 8'd99);
        e.code       = 8'h7E;
        e.expect_rec = 1'b0;
        test_table[11] = e;
        test_name[11]  = "unknown_code";
        test_table[12] = pwm_entry(8'd8, 8'd50);
        test_name[12]  = "pwm_bad_channel";
        test_table[13] = dsm_entry(8'd9, 16'd10, 2'd1, 8'd0);
        test_name[13]  = "dsm_bad_channel";
        // The PWM ack is produced long before the 100 cycle window closes and leads
        e            = dsm_entry(8'd6, 16'd100, 2'd1, 8'd0);
        e.overlap    = 1'b1;
        e.arg2       = {8'd7, 8'd33, 16'h0000};
        e.exp_rec2   = e.exp_rec;
        e.exp_rec    = expect_pwm_rec(e.arg2);
        test_table[14] = e;
        test_name[14]  = "pwm_during_dsm";
    endtask

    // Step 0 goes out on the strobe edge and seeds the edge history
    task automatic drive_dsm(input test_entry_t e);
        int window;
        if (e.code == usb_cmd_proto_pkg::cmd_dsm_measure) begin
            window        = e.arg[23:8];
            dsm_signal_in <= pin_mask(e.arg[31:24], stim_level(e.dsm_mode, e.half_per, 0));
            for (int j = 1; j <= window; j++) begin
                @(posedge clk);
                dsm_signal_in <= pin_mask(e.arg[31:24], stim_level(e.dsm_mode, e.half_per, j));
            end
            @(posedge clk);
            dsm_signal_in <= '0;
        end
    endtask

    task automatic measure_high(input int ch, output logic [15:0] cnt);
        cnt = 16'd0;
        // One full period so a new duty is surely active
        repeat (pwm_period) @(posedge clk);
        repeat (pwm_period) begin
            @(posedge clk);
            if (pwm_pins[ch]) begin
                cnt = cnt + 16'd1;
            end
        end
    endtask

    // ======================================================================
    // Watchdog and test loop
    // ======================================================================

    initial begin
        repeat (n_tests * 2000) @(posedge clk);
        report_failure($sformatf("Watchdog expired after %0d cycles", n_tests * 2000));
    end

    initial begin
        test_entry_t             e;
        periph_pkg::upload_rec_t r;
        logic [15:0]             cnt;
        int                      errs0;
        int                      frames0;
        int                      ch;
        rst_n             = 1'b0;
        usb_data_in       = 8'h00;
        usb_data_valid_in = 1'b0;
        dsm_signal_in     = '0;
        for (int i = 0; i < num_ch; i++) begin
            duty_model[i] = 8'd0;
        end
        build_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < n_tests; i++) begin
            e       = test_table[i];
            errs0   = err_count;
            frames0 = frame_count;
            send_frame(e.code, e.len, e.arg, e.bad_csum);
            fork
                drive_dsm(e);
                begin
                    if (e.overlap) begin
                        send_frame(usb_cmd_proto_pkg::cmd_pwm_set, usb_cmd_proto_pkg::arg_len,
                                   e.arg2, 1'b0);
                    end
                    if (e.expect_rec) begin
                        collect_response(r);
                        check_rec(test_name[i], e.exp_rec, r);
                    end
                    if (e.overlap) begin
                        collect_response(r);
                        check_rec(test_name[i], e.exp_rec2, r);
                    end
                    if (!e.expect_rec) begin
                        repeat (quiet_cycles) @(posedge clk);
                        if (frame_count != frames0) begin
                            report_failure($sformatf("%s sent a response frame it should not",
                                                     test_name[i]));
                        end
                    end
                end
            join
            check_bit(test_name[i], e.expect_err, err_count != errs0);
            if (e.overlap) begin
                duty_model[e.arg2[31:24]] = e.arg2[23:16];
            end
            ch = e.arg[31:24];
            if (e.code == usb_cmd_proto_pkg::cmd_pwm_set && ch < num_ch && !e.overlap) begin
                if (e.expect_rec) begin
                    duty_model[ch] = e.arg[23:16];
                end
                measure_high(ch, cnt);
                check_count(test_name[i], 16'(duty_model[ch] * pwm_div), cnt);
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- usb_cmd_bridge.f
+incdir+testbench
hdl/usb_cmd_proto_pkg.sv
hdl/periph_pkg.sv
hdl/frame_parser.sv
hdl/pwm_handler.sv
hdl/dsm_handler.sv
hdl/upload_framer.sv
hdl/usb_cmd_bridge.sv
testbench/usb_cmd_bridge_tb.sv
